// File: sources.f
hw/accum_pkg.sv
hw/accum_decode.sv
hw/accum_execute.sv
hw/accum_result.sv
hw/accum_core.sv
test/accum_sva.sv
test/accum_checker.sv
test/accum_tb.sv

// File: Makefile
# Verilator build and run of the accumulator core testbench

VERILATOR ?= verilator
TOP       ?= accum_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_FLAGS ?= +verilator+error+limit+100
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/accum_tb.sv
// Testbench for the accumulator core.
// Runs reset, a random burst, transfer and carry sequences and sparse
// strobes and prints one line per test. The checker compares the state on
// every retire and the bound assertions watch the timing.

module accum_tb import accum_pkg::*; ();

    localparam int WIDTH       = ACC_WIDTH_DEFAULT;
    localparam int PERIOD      = 4;
    localparam int BURST_LEN   = 300;
    localparam int SPARSE_LEN  = 40;
    localparam int DRAIN_LIMIT = 8;          // Cycles for the pipeline to empty
    // Reset, idle, burst, transfers, carry chain, sparse with worst gaps, wrap-up
    localparam int TOTAL_CYCLES = 3 + 10 + BURST_LEN + 10 + 20 + 25 + SPARSE_LEN * 5 + 10;

    localparam logic [WIDTH-1:0] ALL_ONES = '1;
    localparam logic [WIDTH-1:0] ONE      = {{(WIDTH-1){1'b0}}, 1'b1};
    localparam logic [WIDTH-1:0] HALF     = {1'b1, {(WIDTH-1){1'b0}}};
    localparam logic [WIDTH-1:0] ALMOST   = {{(WIDTH-1){1'b1}}, 1'b0};

    logic             clk;
    logic             reset;
    logic             instr_valid;
    op_t              instr_op;
    src_t             instr_src;
    logic [WIDTH-1:0] instr_imm;
    logic [WIDTH-1:0] ac, x, y;
    logic             flag_n, flag_z, flag_c;
    logic             retire;
    logic             end_check;

    int seed          = 32'h2ba55bf3;
    int strobe_count  = 0;
    int retire_count  = 0;
    int tb_errors     = 0;
    int errors_before = 0;
    int chk_errors;
    int chk_checks;

    accum_core #(.WIDTH(WIDTH)) dut0 (.*);

    accum_checker #(.WIDTH(WIDTH)) checker0 (
        .*,
        .error_count (chk_errors),
        .check_count (chk_checks)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (!reset && retire)
            retire_count++;
    end

    function automatic int total_errors();
        return tb_errors + chk_errors + dut0.sva0.lat_fails + dut0.sva0.flag_fails
             + dut0.sva0.unknown_fails;
    endfunction

    // -------------------------------------------------------------------------
    // Stimulus tasks drive the inputs 1 unit after the rising edge
    // -------------------------------------------------------------------------
    task automatic issue(input op_t op, input src_t src, input logic [WIDTH-1:0] imm);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr_op    = op;
        instr_src   = src;
        instr_imm   = imm;
        strobe_count++;
    endtask

    task automatic issue_random();
        int r_op;
        int r_imm;
        r_op  = $random(seed);
        r_imm = $random(seed);
        issue(op_t'(r_op[3:0]), src_t'(r_op[5:4]), r_imm[WIDTH-1:0]);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    // Waits for the retire count to catch up with the strobes
    task automatic wait_retired(input string name);
        int waited;
        waited = 0;
        while (retire_count != strobe_count && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (retire_count != strobe_count) begin
            $display("%s: the DUT did not retire every strobed instruction in time", name);
            tb_errors++;
        end
        @(negedge clk);
    endtask

    task automatic close_test(input int num, input string name);
        int now_errors;
        now_errors = total_errors();
        $display("test %0d %s: done, %0d errors", num, name, now_errors - errors_before);
        errors_before = now_errors;
    endtask

    // -------------------------------------------------------------------------
    // Test sequence
    // -------------------------------------------------------------------------
    initial begin
        int gap_rnd;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_op    = OP_NOP;
        instr_src   = SRC_IMM;
        instr_imm   = '0;
        end_check   = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        repeat (10) @(posedge clk);              // State must read zero with no retire
        close_test(1, "reset and idle");

        repeat (BURST_LEN) issue_random();
        idle_cycle();
        wait_retired("random burst");
        close_test(2, "random burst");

        issue(OP_LDA, SRC_IMM, '0);              // Sets Z which the index writes must keep
        issue(OP_LDY, SRC_IMM, ALMOST);
        issue(OP_LDX, SRC_IMM, HALF);
        issue(OP_LDA, SRC_X, '0);                // Sees the LDX just before
        issue(OP_TAY, SRC_IMM, '0);
        issue(OP_LDA, SRC_IMM, ONE);
        issue(OP_TAX, SRC_IMM, '0);
        issue(OP_ADD, SRC_Y, '0);
        issue(OP_LDA, SRC_Y, '0);
        issue(OP_SUB, SRC_X, '0);
        idle_cycle();
        wait_retired("transfers");
        close_test(3, "transfers and index use");

        issue(OP_LDA, SRC_IMM, ALL_ONES);
        issue(OP_ADD, SRC_IMM, ONE);             // Wraps to zero with C and Z set
        issue(OP_ADC, SRC_IMM, '0);              // Old carry gives one
        issue(OP_ADC, SRC_IMM, ALL_ONES);
        issue(OP_ADC, SRC_IMM, ALL_ONES);
        issue(OP_SUB, SRC_IMM, ONE);             // Borrow clears C
        issue(OP_NEG, SRC_IMM, '0);              // C left alone
        issue(OP_SUB, SRC_IMM, ONE);
        issue(OP_NOT, SRC_IMM, '0);
        issue(OP_NEG, SRC_IMM, '0);
        issue(OP_LDA, SRC_IMM, HALF);
        issue(OP_SHL, SRC_IMM, '0);              // Top bit out into C
        issue(OP_SHR, SRC_IMM, '0);
        issue(OP_LDA, SRC_IMM, ONE);
        issue(OP_SHR, SRC_IMM, '0);              // Bottom bit out into C
        issue(OP_SUB, SRC_IMM, ALL_ONES);
        idle_cycle();
        wait_retired("carry chain");
        close_test(4, "carry chain");

        repeat (SPARSE_LEN) begin
            issue_random();
            gap_rnd = $random(seed);
            repeat ((gap_rnd & 3) + 1) idle_cycle();
        end
        wait_retired("sparse strobes");
        close_test(5, "sparse strobes");

        end_check = 1'b1;
        repeat (2) @(negedge clk);
        $display("summary: 5 tests, %0d strobes, %0d retires checked, %0d errors",
                 strobe_count, chk_checks, total_errors());
        if (total_errors() == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog ends the run after twice the expected length of all tests
    initial begin
        #(2 * TOTAL_CYCLES * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

// File: test/accum_checker.sv
// Reference model and scoreboard for the accumulator core.
// Applies each strobed instruction to a model of AC, X, Y and the flags,
// queues the expected state and compares it with the DUT on every retire.
// Between retires the DUT must hold the state of the last retire.

module accum_checker import accum_pkg::*; #(
    parameter int WIDTH = ACC_WIDTH_DEFAULT
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    input  op_t              instr_op,
    input  src_t             instr_src,
    input  logic [WIDTH-1:0] instr_imm,
    input  logic [WIDTH-1:0] ac,
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             flag_n,
    input  logic             flag_z,
    input  logic             flag_c,
    input  logic             retire,
    input  logic             end_check,     // High once all tests are done
    output int               error_count,
    output int               check_count    // Retires compared
);

    localparam int SW = 3 * WIDTH + 3;      // {ac, x, y, n, z, c}

    logic [WIDTH-1:0] m_ac, m_x, m_y;       // Model state after the last accepted strobe
    logic             m_n, m_z, m_c;
    logic [SW-1:0]    committed;            // State of the last retire
    logic [SW-1:0]    exp_q[$];             // Strobed but not yet retired
    logic             end_done;

    // -------------------------------------------------------------------------
    // Instruction model
    // -------------------------------------------------------------------------
    task automatic apply_instr(input op_t op, input src_t src, input logic [WIDTH-1:0] imm);
        logic [WIDTH-1:0] opnd;
        logic [WIDTH:0]   cin;
        logic [WIDTH:0]   sum;
        opnd   = (src == SRC_X) ? m_x : (src == SRC_Y) ? m_y : imm;   // Code 3 acts as IMM
        cin    = '0;
        cin[0] = (op == OP_ADC) ? m_c : 1'b0;
        sum    = {1'b0, m_ac} + {1'b0, opnd} + cin;
        case (op)
            OP_LDA: m_ac = opnd;
            OP_ADD,
            OP_ADC: begin
                m_c  = sum[WIDTH];
                m_ac = sum[WIDTH-1:0];
            end
            OP_SUB: begin
                m_c  = (m_ac >= opnd);      // Set when no borrow
                m_ac = m_ac - opnd;
            end
            OP_AND: m_ac = m_ac & opnd;
            OP_OR:  m_ac = m_ac | opnd;
            OP_XOR: m_ac = m_ac ^ opnd;
            OP_NOT: m_ac = ~m_ac;
            OP_NEG: m_ac = ~m_ac + {{(WIDTH-1){1'b0}}, 1'b1};
            OP_SHL: begin
                m_c  = m_ac[WIDTH-1];
                m_ac = m_ac << 1;
            end
            OP_SHR: begin
                m_c  = m_ac[0];
                m_ac = m_ac >> 1;           // Logical
            end
            OP_LDX: m_x = opnd;
            OP_LDY: m_y = opnd;
            OP_TAX: m_x = m_ac;
            OP_TAY: m_y = m_ac;
            default: ;
        endcase
        // Every op from LDA to SHR writes AC and loads N and Z
        if (op != OP_NOP && op < OP_LDX) begin
            m_n = m_ac[WIDTH-1];
            m_z = (m_ac == '0);
        end
    endtask

    task automatic check_word(input string name, input logic [WIDTH-1:0] exp,
                              input logic [WIDTH-1:0] got);
        if (got !== exp) begin
            $display("ERROR: %s expected %h got %h at time %0t", name, exp, got, $time);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERROR: %s expected %h got %h at time %0t", name, exp, got, $time);
            error_count++;
        end
    endtask

    // -------------------------------------------------------------------------
    // Scoreboard, sampled mid-cycle where inputs and outputs are settled
    // -------------------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            {m_ac, m_x, m_y, m_n, m_z, m_c} = '0;
            committed = '0;
            exp_q.delete();
            end_done = 1'b0;
        end else begin
            if (retire) begin
                if (exp_q.size() == 0) begin
                    $display("Retire at time %0t with no instruction pending", $time);
                    error_count++;
                end else begin
                    committed = exp_q.pop_front();
                    check_count++;
                end
            end
            check_word("ac", committed[SW-1 -: WIDTH], ac);
            check_word("x", committed[2*WIDTH+2 -: WIDTH], x);
            check_word("y", committed[WIDTH+2 -: WIDTH], y);
            check_bit("flag_n", committed[2], flag_n);
            check_bit("flag_z", committed[1], flag_z);
            check_bit("flag_c", committed[0], flag_c);
            if (instr_valid) begin
                apply_instr(instr_op, instr_src, instr_imm);
                exp_q.push_back({m_ac, m_x, m_y, m_n, m_z, m_c});
            end
            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d instruction(s) still pending when the run ended",
                             exp_q.size());
                    error_count++;
                end
            end
        end
    end

endmodule

// File: test/accum_sva.sv
// Bound assertions for the accumulator core.
// Check the two-edge strobe to retire latency, that the flags move only
// with a retire, and that no output is unknown once reset is released.
// The testbench reads the failure counters at the end of the run.

module accum_sva import accum_pkg::*; #(
    parameter int WIDTH = ACC_WIDTH_DEFAULT
) (
    input logic             clk,
    input logic             reset,
    input logic             instr_valid,
    input logic             retire,
    input logic [WIDTH-1:0] ac,
    input logic [WIDTH-1:0] x,
    input logic [WIDTH-1:0] y,
    input logic             flag_n,
    input logic             flag_z,
    input logic             flag_c
);

    int lat_fails     = 0;   // One counter per assertion
    int flag_fails    = 0;
    int unknown_fails = 0;

    // Sampled at edge k, written at k+1, retire seen at k+2
    a_latency: assert property (@(posedge clk) disable iff (reset)
        retire == $past(instr_valid, 2))
        else begin
            $error("retire does not follow the strobe by two edges");
            lat_fails++;
        end

    a_flags: assert property (@(posedge clk) disable iff (reset)
        !retire |-> $stable({flag_n, flag_z, flag_c}))
        else begin
            $error("flags changed without a retire");
            flag_fails++;
        end

    a_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({ac, x, y, flag_n, flag_z, flag_c, retire}))
        else begin
            $error("core output is unknown");
            unknown_fails++;
        end

endmodule

bind accum_core accum_sva #(.WIDTH(WIDTH)) sva0 (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .retire      (retire),
    .ac          (ac),
    .x           (x),
    .y           (y),
    .flag_n      (flag_n),
    .flag_z      (flag_z),
    .flag_c      (flag_c)
);

// File: hw/accum_core.sv
// Top level of the accumulator execution core.
// Decode, execute and result stages in a row. An instruction strobed at one
// edge updates AC, X, Y and the flags at the next edge, and retire is high
// in the cycle after that update. A strobe may arrive on every cycle.

module accum_core import accum_pkg::*; #(
    parameter int WIDTH = ACC_WIDTH_DEFAULT
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    input  op_t              instr_op,
    input  src_t             instr_src,
    input  logic [WIDTH-1:0] instr_imm,
    output logic [WIDTH-1:0] ac,
    output logic [WIDTH-1:0] x,
    output logic [WIDTH-1:0] y,
    output logic             flag_n,
    output logic             flag_z,
    output logic             flag_c,
    output logic             retire
);

    // -------------------------------------------------------------------------
    // Stage wiring
    // -------------------------------------------------------------------------
    logic             dec_valid;     // Decode to execute
    alu_fn_t          dec_fn;
    src_t             dec_src;
    logic [WIDTH-1:0] dec_imm;
    dest_t            dec_dest;
    logic             dec_nz_en;
    logic             dec_c_en;

    logic             ex_valid;      // Execute to result
    dest_t            ex_dest;
    logic [WIDTH-1:0] ex_value;
    logic             ex_n;
    logic             ex_z;
    logic             ex_c;
    logic             ex_nz_en;
    logic             ex_c_en;

    accum_decode #(.WIDTH(WIDTH)) u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_op    (instr_op),
        .instr_src   (instr_src),
        .instr_imm   (instr_imm),
        .dec_valid   (dec_valid),
        .dec_fn      (dec_fn),
        .dec_src     (dec_src),
        .dec_imm     (dec_imm),
        .dec_dest    (dec_dest),
        .dec_nz_en   (dec_nz_en),
        .dec_c_en    (dec_c_en)
    );

    // Execute reads the live state, no forwarding needed
    accum_execute #(.WIDTH(WIDTH)) u_execute (
        .dec_valid (dec_valid),
        .dec_fn    (dec_fn),
        .dec_src   (dec_src),
        .dec_imm   (dec_imm),
        .dec_dest  (dec_dest),
        .dec_nz_en (dec_nz_en),
        .dec_c_en  (dec_c_en),
        .ac        (ac),
        .x         (x),
        .y         (y),
        .flag_c    (flag_c),
        .ex_valid  (ex_valid),
        .ex_dest   (ex_dest),
        .ex_value  (ex_value),
        .ex_n      (ex_n),
        .ex_z      (ex_z),
        .ex_c      (ex_c),
        .ex_nz_en  (ex_nz_en),
        .ex_c_en   (ex_c_en)
    );

    accum_result #(.WIDTH(WIDTH)) u_result (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_dest  (ex_dest),
        .ex_value (ex_value),
        .ex_n     (ex_n),
        .ex_z     (ex_z),
        .ex_c     (ex_c),
        .ex_nz_en (ex_nz_en),
        .ex_c_en  (ex_c_en),
        .ac       (ac),
        .x        (x),
        .y        (y),
        .flag_n   (flag_n),
        .flag_z   (flag_z),
        .flag_c   (flag_c),
        .retire   (retire)
    );

endmodule

// File: hw/accum_result.sv
// Result stage of the accumulator core.
// Holds AC, X, Y and the N, Z and C flags. A valid result from execute is
// written on the next edge and retire pulses for one cycle after it, in the
// same cycle the new state shows up on the outputs.

module accum_result import accum_pkg::*; #(
    parameter int WIDTH = ACC_WIDTH_DEFAULT
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             ex_valid,
    input  dest_t            ex_dest,
    input  logic [WIDTH-1:0] ex_value,
    input  logic             ex_n,
    input  logic             ex_z,
    input  logic             ex_c,
    input  logic             ex_nz_en,
    input  logic             ex_c_en,
    output logic [WIDTH-1:0] ac,
    output logic [WIDTH-1:0] x,
    output logic [WIDTH-1:0] y,
    output logic             flag_n,
    output logic             flag_z,
    output logic             flag_c,
    output logic             retire       // One pulse per instruction
);

    logic wr_ac;
    logic wr_x;
    logic wr_y;

    // Register write enables
    assign wr_ac = ex_valid && (ex_dest == DEST_AC);
    assign wr_x  = ex_valid && (ex_dest == DEST_X);
    assign wr_y  = ex_valid && (ex_dest == DEST_Y);

    // -------------------------------------------------------------------------
    // Architectural registers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ac <= '0;
            x  <= '0;
            y  <= '0;
        end else begin
            if (wr_ac)
                ac <= ex_value;
            if (wr_x)
                x <= ex_value;
            if (wr_y)
                y <= ex_value;
        end
    end

    // N/Z and C load under separate enables
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flag_n <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else begin
            if (ex_valid && ex_nz_en) begin
                flag_n <= ex_n;
                flag_z <= ex_z;
            end
            if (ex_valid && ex_c_en)
                flag_c <= ex_c;
        end
    end

    // Retire marks the cycle the new state is visible, NOPs included
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            retire <= 1'b0;
        else
            retire <= ex_valid;
    end

endmodule

// File: hw/accum_execute.sv
// Execute stage of the accumulator core, purely combinational.
// Picks the operand (immediate, X or Y), runs the ALU against AC and
// produces the write-back value with the new N, Z and C.
// Reads the architectural state straight from the result stage, so an
// instruction always sees its predecessor's write.

module accum_execute import accum_pkg::*; #(
    parameter int WIDTH = ACC_WIDTH_DEFAULT
) (
    input  logic             dec_valid,
    input  alu_fn_t          dec_fn,
    input  src_t             dec_src,
    input  logic [WIDTH-1:0] dec_imm,
    input  dest_t            dec_dest,
    input  logic             dec_nz_en,
    input  logic             dec_c_en,
    input  logic [WIDTH-1:0] ac,           // Current architectural state
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             flag_c,
    output logic             ex_valid,
    output dest_t            ex_dest,
    output logic [WIDTH-1:0] ex_value,
    output logic             ex_n,
    output logic             ex_z,
    output logic             ex_c,
    output logic             ex_nz_en,
    output logic             ex_c_en
);

    logic [WIDTH-1:0] opnd;       // Selected second operand
    logic             carry_in;   // Only ADC folds in the old carry
    logic [WIDTH:0]   add_sum;    // Extra top bit is the carry out
    logic [WIDTH:0]   sub_diff;   // Extra top bit is the borrow

    // -------------------------------------------------------------------------
    // Operand select
    // -------------------------------------------------------------------------
    always_comb begin
        case (dec_src)
            SRC_X:   opnd = x;
            SRC_Y:   opnd = y;
            default: opnd = dec_imm;  // IMM and the spare code
        endcase
    end

    assign carry_in = (dec_fn == FN_ADC) ? flag_c : 1'b0;

    // Shared adder for ADD and ADC
    assign add_sum  = {1'b0, ac} + {1'b0, opnd} + {{WIDTH{1'b0}}, carry_in};
    assign sub_diff = {1'b0, ac} - {1'b0, opnd};

    // -------------------------------------------------------------------------
    // ALU
    // -------------------------------------------------------------------------
    always_comb begin
        ex_value = opnd;
        ex_c     = flag_c;   // Unchanged unless the function defines it
        case (dec_fn)
            FN_PASS:    ex_value = opnd;
            FN_ADD,
            FN_ADC: begin
                ex_value = add_sum[WIDTH-1:0];
                ex_c     = add_sum[WIDTH];
            end
            FN_SUB: begin
                ex_value = sub_diff[WIDTH-1:0];
                ex_c     = ~sub_diff[WIDTH];          // Set when no borrow
            end
            FN_AND:     ex_value = ac & opnd;
            FN_OR:      ex_value = ac | opnd;
            FN_XOR:     ex_value = ac ^ opnd;
            FN_NOT:     ex_value = ~ac;
            FN_NEG:     ex_value = '0 - ac;
            FN_SHL: begin
                ex_value = {ac[WIDTH-2:0], 1'b0};
                ex_c     = ac[WIDTH-1];               // Bit shifted out at the top
            end
            FN_SHR: begin
                ex_value = {1'b0, ac[WIDTH-1:1]};     // Logical, zero fill
                ex_c     = ac[0];
            end
            FN_PASS_AC: ex_value = ac;
            default:    ex_value = opnd;
        endcase
    end

    // Flags from the result itself
    assign ex_n = ex_value[WIDTH-1];
    assign ex_z = (ex_value == '0);

    // Control rides along with the result
    assign ex_valid = dec_valid;
    assign ex_dest  = dec_dest;
    assign ex_nz_en = dec_valid & dec_nz_en;
    assign ex_c_en  = dec_valid & dec_c_en;

endmodule

// File: hw/accum_decode.sv
// Decode stage of the accumulator core.
// Samples the instruction strobe and turns the opcode into an ALU function,
// a write destination and flag enables, all presented one cycle later.

module accum_decode import accum_pkg::*; #(
    parameter int WIDTH = ACC_WIDTH_DEFAULT
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,  // Single-cycle strobe
    input  op_t              instr_op,
    input  src_t             instr_src,
    input  logic [WIDTH-1:0] instr_imm,
    output logic             dec_valid,
    output alu_fn_t          dec_fn,
    output src_t             dec_src,
    output logic [WIDTH-1:0] dec_imm,
    output dest_t            dec_dest,
    output logic             dec_nz_en,    // Load N and Z at retire
    output logic             dec_c_en      // Load C at retire
);

    alu_fn_t nxt_fn;
    dest_t   nxt_dest;
    logic    nxt_nz_en;
    logic    nxt_c_en;

    // -------------------------------------------------------------------------
    // Opcode map
    // -------------------------------------------------------------------------
    always_comb begin
        case (instr_op)
            OP_ADD:         nxt_fn = FN_ADD;
            OP_ADC:         nxt_fn = FN_ADC;
            OP_SUB:         nxt_fn = FN_SUB;
            OP_AND:         nxt_fn = FN_AND;
            OP_OR:          nxt_fn = FN_OR;
            OP_XOR:         nxt_fn = FN_XOR;
            OP_NOT:         nxt_fn = FN_NOT;
            OP_NEG:         nxt_fn = FN_NEG;
            OP_SHL:         nxt_fn = FN_SHL;
            OP_SHR:         nxt_fn = FN_SHR;
            OP_TAX, OP_TAY: nxt_fn = FN_PASS_AC;
            default:        nxt_fn = FN_PASS;     // NOP, LDA, LDX and LDY
        endcase
    end

    always_comb begin
        case (instr_op)
            OP_NOP:         nxt_dest = DEST_NONE;  // NOP writes nothing
            OP_LDX, OP_TAX: nxt_dest = DEST_X;
            OP_LDY, OP_TAY: nxt_dest = DEST_Y;
            default:        nxt_dest = DEST_AC;
        endcase
    end

    // Every write of AC loads N and Z, index register writes leave every flag alone
    assign nxt_nz_en = (nxt_dest == DEST_AC);

    // Only the arithmetic ops and the shifts load C
    assign nxt_c_en  = instr_op inside {OP_ADD, OP_ADC, OP_SUB, OP_SHL, OP_SHR};

    // -------------------------------------------------------------------------
    // Pipeline register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_dest  <= DEST_NONE;
            dec_nz_en <= 1'b0;
            dec_c_en  <= 1'b0;
        end else begin
            dec_valid <= instr_valid;                           // One stage per strobe
            dec_dest  <= instr_valid ? nxt_dest : DEST_NONE;
            dec_nz_en <= instr_valid & nxt_nz_en;
            dec_c_en  <= instr_valid & nxt_c_en;
        end
    end

    // Operand payload is captured only with a strobe
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_fn  <= nxt_fn;
            dec_src <= instr_src;
            dec_imm <= instr_imm;
        end
    end

endmodule

// File: hw/accum_pkg.sv
// Shared types for the accumulator execution core.
// Opcodes arrive on the instruction port. ALU functions, operand sources
// and write destinations travel between the decode, execute and result stages.
// Every stage imports this package in its module header.

package accum_pkg;

    // Default data path width, overridden through the core parameter
    parameter int ACC_WIDTH_DEFAULT = 16;

    // -------------------------------------------------------------------------
    // Instruction opcodes (4 bits, all sixteen codes in use)
    // -------------------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,  // Retires, writes nothing
        OP_LDA = 4'h1,  // AC <- operand
        OP_ADD = 4'h2,  // AC <- AC + operand
        OP_ADC = 4'h3,  // AC <- AC + operand + C
        OP_SUB = 4'h4,  // AC <- AC - operand
        OP_AND = 4'h5,
        OP_OR  = 4'h6,
        OP_XOR = 4'h7,
        OP_NOT = 4'h8,  // One's complement of AC
        OP_NEG = 4'h9,  // Two's complement of AC
        OP_SHL = 4'hA,  // Shift AC left by one
        OP_SHR = 4'hB,  // Logical shift AC right by one
        OP_LDX = 4'hC,  // X <- operand
        OP_LDY = 4'hD,  // Y <- operand
        OP_TAX = 4'hE,  // X <- AC
        OP_TAY = 4'hF   // Y <- AC
    } op_t;

    // Operand source, code 3 is unnamed and falls back to the immediate
    typedef enum logic [1:0] {
        SRC_IMM = 2'd0,
        SRC_X   = 2'd1,
        SRC_Y   = 2'd2
    } src_t;

    // -------------------------------------------------------------------------
    // ALU functions seen by the execute stage
    // -------------------------------------------------------------------------
    typedef enum logic [3:0] {
        FN_PASS    = 4'd0,   // Result is the operand
        FN_ADD     = 4'd1,
        FN_ADC     = 4'd2,
        FN_SUB     = 4'd3,
        FN_AND     = 4'd4,
        FN_OR      = 4'd5,
        FN_XOR     = 4'd6,
        FN_NOT     = 4'd7,
        FN_NEG     = 4'd8,
        FN_SHL     = 4'd9,
        FN_SHR     = 4'd10,
        FN_PASS_AC = 4'd11   // Result is AC itself (TAX, TAY)
    } alu_fn_t;

    // Register written back at retire
    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_AC   = 2'd1,
        DEST_X    = 2'd2,
        DEST_Y    = 2'd3
    } dest_t;

endpackage
